//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = msdft_tb
FILELIST = filelist.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

//--- bench/msdft_checker.sv
`default_nettype none

module msdft_checker #(
    parameter int DFT_LEN = 64
) (
    input wire logic                        clk,
    input wire logic                        rst,
    input wire logic                        din_valid,
    input wire logic                        dout_valid,
    input wire logic [$clog2(DFT_LEN)-1:0]  cfg_addr,
    input wire logic                        cfg_we,
    input wire msdft_pkg::twidd_word_t      cfg_data,
    input wire msdft_pkg::twidd_word_t      cfg_dout
);

    // comb, table read, two multiplier stages, integrator, cast.
    latency_fwd: assert property (@(posedge clk) disable iff (rst)
        din_valid |-> ##6 dout_valid)
        else $error("dout_valid missing six edges after din_valid");

    latency_back: assert property (@(posedge clk) disable iff (rst)
        dout_valid |-> $past(din_valid, 6))
        else $error("dout_valid without din_valid six edges earlier");

    quiet_in_reset: assert property (@(posedge clk)
        $past(rst) |-> !dout_valid)
        else $error("dout_valid raised while in reset");

    // a read right after a write to the same entry sees the new word.
    cfg_readback: assert property (@(posedge clk)
        (!cfg_we && $past(cfg_we) && cfg_addr == $past(cfg_addr))
        |=> cfg_dout == $past(cfg_data, 2))
        else $error("cfg_dout does not return the word written to the table");

endmodule

bind msdft_top msdft_checker #(.DFT_LEN(DFT_LEN)) checker_i (
    .clk        (clk),
    .rst        (rst),
    .din_valid  (din_valid),
    .dout_valid (dout_valid),
    .cfg_addr   (cfg_addr),
    .cfg_we     (cfg_we),
    .cfg_data   (cfg_data),
    .cfg_dout   (cfg_dout)
);

`default_nettype wire

//--- bench/msdft_tb.sv
`default_nettype none

module msdft_tb;

    localparam int dft_len = 64;
    localparam int aw = $clog2(dft_len);
    localparam int drain_limit = 2000;
    localparam int frac_shift = msdft_pkg::din_point + msdft_pkg::twidd_point
        - msdft_pkg::dout_point;
    localparam longint out_max = (64'sd1 <<< (msdft_pkg::dout_w - 1)) - 64'sd1;
    localparam longint out_min = -out_max - 64'sd1;

    logic                   clk;
    logic                   rst;
    msdft_pkg::sample_t     din_re;
    msdft_pkg::sample_t     din_im;
    logic                   din_valid;
    logic [aw-1:0]          len_m1;
    logic [aw-1:0]          cfg_addr;
    msdft_pkg::twidd_word_t cfg_data;
    logic                   cfg_we;
    msdft_pkg::twidd_word_t cfg_dout;
    msdft_pkg::dout_t       dout_re;
    msdft_pkg::dout_t       dout_im;
    logic                   dout_valid;

    // reference model state.
    int     tw_re [dft_len];
    int     tw_im [dft_len];
    int     hist_re [dft_len];
    int     hist_im [dft_len];
    int     m_len;
    int     m_ptr;
    int     m_idx;
    bit     m_filled;
    longint acc_re;
    longint acc_im;

    msdft_pkg::dout_t exp_re [$];
    msdft_pkg::dout_t exp_im [$];
    msdft_pkg::dout_t last_re;
    msdft_pkg::dout_t last_im;
    int seed = 32'hbd22f821;
    int n_recv;
    int n_start;
    real angle;

    msdft_top #(.DFT_LEN(dft_len)) dut_i (
        .clk        (clk),
        .rst        (rst),
        .din_re     (din_re),
        .din_im     (din_im),
        .din_valid  (din_valid),
        .len_m1     (len_m1),
        .cfg_addr   (cfg_addr),
        .cfg_data   (cfg_data),
        .cfg_we     (cfg_we),
        .cfg_dout   (cfg_dout),
        .dout_re    (dout_re),
        .dout_im    (dout_im),
        .dout_valid (dout_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    function automatic longint floor_sat(input longint acc);
        longint v;
        v = acc >>> frac_shift; // floor.
        if (v > out_max) begin
            v = out_max;
        end else if (v < out_min) begin
            v = out_min;
        end
        return v;
    endfunction

    function automatic void model_reset(input int len);
        for (int i = 0; i < dft_len; i++) begin
            hist_re[i] = 0;
            hist_im[i] = 0;
        end
        m_len = len;
        m_ptr = 0;
        m_idx = 0;
        m_filled = 1'b0;
        acc_re = 0;
        acc_im = 0;
    endfunction

    // one step of comb, rotation, integration and cast.
    function automatic void ref_bin(input int xr, input int xi,
                                    output longint yr, output longint yi);
        longint c_r;
        longint c_i;
        c_r = xr - (m_filled ? hist_re[m_ptr] : 0);
        c_i = xi - (m_filled ? hist_im[m_ptr] : 0);
        hist_re[m_ptr] = xr;
        hist_im[m_ptr] = xi;
        if (m_ptr == m_len - 1) begin
            m_ptr = 0;
            m_filled = 1'b1;
        end else begin
            m_ptr++;
        end
        acc_re += c_r * tw_re[m_idx] - c_i * tw_im[m_idx];
        acc_im += c_r * tw_im[m_idx] + c_i * tw_re[m_idx];
        m_idx = (m_idx == m_len - 1) ? 0 : m_idx + 1;
        yr = floor_sat(acc_re);
        yi = floor_sat(acc_im);
    endfunction

    function automatic int to_fixed(input real v, input int point);
        real scaled;
        scaled = v * real'(1 << point);
        return (scaled >= 0.0) ? $rtoi(scaled + 0.5) : -$rtoi(-scaled + 0.5);
    endfunction

    function automatic int rand_sample();
        logic signed [15:0] v;
        v = 16'($random(seed));
        return v;
    endfunction

    task automatic write_table(input int k, input int len, input bit unity);
        real a;
        for (int n = 0; n < len; n++) begin
            a = 2.0 * 3.14159265358979 * k * n / len;
            tw_re[n] = unity ? (1 << msdft_pkg::twidd_point) : to_fixed($cos(a), 14);
            tw_im[n] = unity ? 0 : to_fixed($sin(a), 14);
            @(posedge clk);
            cfg_we <= 1'b1;
            cfg_addr <= aw'(n);
            cfg_data <= {16'(tw_re[n]), 16'(tw_im[n])};
        end
        @(posedge clk);
        cfg_we <= 1'b0;
    endtask

    task automatic read_table(input int len);
        for (int n = 0; n < len; n++) begin
            @(posedge clk);
            cfg_addr <= aw'(n);
            @(posedge clk);
            @(negedge clk);
            check_equal("cfg_dout", cfg_dout, {16'(tw_re[n]), 16'(tw_im[n])});
        end
    endtask

    task automatic send_sample(input int xr, input int xi);
        longint yr;
        longint yi;
        @(posedge clk);
        din_re <= 16'(xr);
        din_im <= 16'(xi);
        din_valid <= 1'b1;
        ref_bin(xr, xi, yr, yi);
        exp_re.push_back(32'(yr));
        exp_im.push_back(32'(yi));
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            din_valid <= 1'b0;
        end
    endtask

    task automatic send_random(input int count);
        for (int i = 0; i < count; i++) begin
            send_sample(rand_sample(), rand_sample());
            if (($random(seed) & 3) == 0) begin
                idle(1 + ($random(seed) & 3));
            end
        end
        idle(1);
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_re.size() != 0 && t <= drain_limit) begin
            @(posedge clk);
            t++;
        end
        if (exp_re.size() != 0) begin
            abort_run("Timed out waiting for the DUT to deliver all results");
        end
    endtask

    // new length goes in with reset, results in flight are dropped.
    task automatic apply_reset(input int len, input int cycles);
        @(posedge clk);
        din_valid <= 1'b0;
        rst <= 1'b1;
        len_m1 <= aw'(len - 1);
        repeat (cycles) @(posedge clk);
        rst <= 1'b0;
        exp_re.delete();
        exp_im.delete();
        model_reset(len);
    endtask

    always @(negedge clk) begin
        if (dout_valid) begin
            if (exp_re.size() == 0) begin
                abort_run("DUT produced a result with no sample pending");
            end else begin
                check_equal("dout_re", dout_re, exp_re.pop_front());
                check_equal("dout_im", dout_im, exp_im.pop_front());
                last_re = dout_re;
                last_im = dout_im;
                n_recv++;
            end
        end
    end

    initial begin
        rst = 1'b1;
        din_re = '0;
        din_im = '0;
        din_valid = 1'b0;
        len_m1 = aw'(dft_len - 1);
        cfg_addr = '0;
        cfg_data = '0;
        cfg_we = 1'b0;
        n_recv = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        model_reset(dft_len);

        write_table(5, dft_len, 1'b0);
        read_table(dft_len);

        // conjugate tone at bin 5 so the rotated terms add up.
        for (int n = 0; n < 2 * dft_len; n++) begin
            angle = 2.0 * 3.14159265358979 * 5 * (n % dft_len) / dft_len;
            send_sample(to_fixed(0.5 * $cos(angle), 15), to_fixed(-0.5 * $sin(angle), 15));
        end
        idle(1);
        wait_drain();
        // half scale tone settles at L/2, imaginary part near zero.
        check_equal("settled dout_re", (last_re + 32'sd32768) >>> msdft_pkg::dout_point,
                    dft_len / 2);
        check_equal("settled dout_im", (last_im + 32'sd32768) >>> msdft_pkg::dout_point, 0);

        n_start = n_recv;
        send_random(200);
        wait_drain();
        check_equal("output count", n_recv - n_start, 200);

        apply_reset(dft_len / 4, 16);
        write_table(2, dft_len / 4, 1'b0);
        read_table(dft_len / 4);
        send_random(3 * dft_len / 4);
        wait_drain();

        // full scale against a unity twiddle.
        apply_reset(dft_len, 16);
        write_table(0, dft_len, 1'b1);
        for (int n = 0; n < 2 * dft_len; n++) begin
            send_sample(32767, -32768);
        end
        idle(1);
        wait_drain();

        for (int n = 0; n < 40; n++) begin
            send_sample(rand_sample(), rand_sample());
        end
        apply_reset(dft_len, 4);
        send_random(100);
        wait_drain();

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/comb.sv
`default_nettype none

module comb #(
    parameter int DFT_LEN = 64
) (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire msdft_pkg::sample_t          din,
    input  wire logic                        din_valid,
    input  wire logic [$clog2(DFT_LEN)-1:0]  len_m1,
    output msdft_pkg::comb_t                 dout,
    output logic                             dout_valid
);

    localparam int addr_w = $clog2(DFT_LEN);

    msdft_pkg::sample_t mem [DFT_LEN];
    logic [addr_w-1:0]  wr_ptr;
    logic               filled;
    msdft_pkg::sample_t old_sample;

    // history reads as zero until the window has been filled once.
    assign old_sample = filled ? mem[wr_ptr] : '0;

    always_ff @(posedge clk) begin
        if (din_valid) begin
            mem[wr_ptr] <= din;
            dout <= din - old_sample; // x[n] - x[n-L].
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            filled <= 1'b0;
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= din_valid;
            if (din_valid) begin
                // >= keeps the pointer in range if len_m1 shrinks.
                if (wr_ptr >= len_m1) begin
                    wr_ptr <= '0;
                    filled <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/complex_mult.sv
`default_nettype none

module complex_mult (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire msdft_pkg::comb_t   a_re,
    input  wire msdft_pkg::comb_t   a_im,
    input  wire msdft_pkg::twidd_t  b_re,
    input  wire msdft_pkg::twidd_t  b_im,
    input  wire logic               din_valid,
    output msdft_pkg::prod_t        p_re,
    output msdft_pkg::prod_t        p_im,
    output logic                    dout_valid
);

    localparam int pp_w = msdft_pkg::din_w + 1 + msdft_pkg::twidd_w;

    logic signed [pp_w-1:0] rr;
    logic signed [pp_w-1:0] ii;
    logic signed [pp_w-1:0] ri;
    logic signed [pp_w-1:0] ir;
    logic                   pp_valid;

    // stage one, partial products.
    always_ff @(posedge clk) begin
        rr <= a_re * b_re;
        ii <= a_im * b_im;
        ri <= a_re * b_im;
        ir <= a_im * b_re;
    end

    // stage two, full width sums.
    always_ff @(posedge clk) begin
        p_re <= rr - ii;
        p_im <= ri + ir;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pp_valid <= 1'b0;
            dout_valid <= 1'b0;
        end else begin
            pp_valid <= din_valid;
            dout_valid <= pp_valid;
        end
    end

endmodule

`default_nettype wire

//--- design/msdft.sv
`default_nettype none

module msdft #(
    parameter int DFT_LEN = 64
) (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire msdft_pkg::sample_t          din_re,
    input  wire msdft_pkg::sample_t          din_im,
    input  wire logic                        din_valid,
    input  wire logic [$clog2(DFT_LEN)-1:0]  len_m1,
    output logic [$clog2(DFT_LEN)-1:0]       twidd_addr,
    input  wire msdft_pkg::twidd_word_t      twidd_word,
    output msdft_pkg::dout_t                 dout_re,
    output msdft_pkg::dout_t                 dout_im,
    output logic                             dout_valid
);

    localparam int addr_w = $clog2(DFT_LEN);
    localparam int integ_w = msdft_pkg::prod_w + addr_w;

    msdft_pkg::comb_t       comb_re;
    msdft_pkg::comb_t       comb_im;
    logic                   comb_valid;
    msdft_pkg::comb_t       comb_re_r;
    msdft_pkg::comb_t       comb_im_r;
    logic                   twidd_valid;
    msdft_pkg::twidd_t      twidd_re;
    msdft_pkg::twidd_t      twidd_im;
    msdft_pkg::prod_t       mult_re;
    msdft_pkg::prod_t       mult_im;
    logic                   mult_valid;
    logic signed [integ_w-1:0] integ_re;
    logic signed [integ_w-1:0] integ_im;
    logic                   integ_valid;
    logic                   cast_valid;

    comb #(.DFT_LEN(DFT_LEN)) comb_re_inst (
        .clk        (clk),
        .rst        (rst),
        .din        (din_re),
        .din_valid  (din_valid),
        .len_m1     (len_m1),
        .dout       (comb_re),
        .dout_valid (comb_valid)
    );

    comb #(.DFT_LEN(DFT_LEN)) comb_im_inst (
        .clk        (clk),
        .rst        (rst),
        .din        (din_im),
        .din_valid  (din_valid),
        .len_m1     (len_m1),
        .dout       (comb_im),
        .dout_valid ()
    );

    // comb delayed one edge to meet the table read.
    always_ff @(posedge clk) begin
        comb_re_r <= comb_re;
        comb_im_r <= comb_im;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            twidd_addr <= '0;
            twidd_valid <= 1'b0;
        end else begin
            twidd_valid <= comb_valid;
            if (comb_valid) begin
                twidd_addr <= (twidd_addr >= len_m1) ? '0 : twidd_addr + 1'b1;
            end
        end
    end

    assign twidd_re = twidd_word[2*msdft_pkg::twidd_w-1 -: msdft_pkg::twidd_w];
    assign twidd_im = twidd_word[msdft_pkg::twidd_w-1:0];

    complex_mult mult_inst (
        .clk        (clk),
        .rst        (rst),
        .a_re       (comb_re_r),
        .a_im       (comb_im_r),
        .b_re       (twidd_re),
        .b_im       (twidd_im),
        .din_valid  (twidd_valid),
        .p_re       (mult_re),
        .p_im       (mult_im),
        .dout_valid (mult_valid)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            integ_re <= '0;
            integ_im <= '0;
            integ_valid <= 1'b0;
        end else begin
            integ_valid <= mult_valid;
            if (mult_valid) begin
                integ_re <= integ_re + mult_re;
                integ_im <= integ_im + mult_im;
            end
        end
    end

    // flush the last strobe on reset.
    assign cast_valid = integ_valid && !rst;

    signed_cast #(
        .DIN_W     (integ_w),
        .DIN_POINT (msdft_pkg::prod_point)
    ) cast_re_inst (
        .clk        (clk),
        .din        (integ_re),
        .din_valid  (cast_valid),
        .dout       (dout_re),
        .dout_valid (dout_valid)
    );

    signed_cast #(
        .DIN_W     (integ_w),
        .DIN_POINT (msdft_pkg::prod_point)
    ) cast_im_inst (
        .clk        (clk),
        .din        (integ_im),
        .din_valid  (cast_valid),
        .dout       (dout_im),
        .dout_valid ()
    );

endmodule

`default_nettype wire

//--- design/msdft_pkg.sv
`default_nettype none

package msdft_pkg;

    // input samples, Q1.15.
    localparam int din_w = 16;
    localparam int din_point = 15;

    // twiddle parts, Q2.14 so that +1.0 is representable.
    localparam int twidd_w = 16;
    localparam int twidd_point = 14;

    // output bins.
    localparam int dout_w = 32;
    localparam int dout_point = 16;

    // comb value times twiddle, plus one bit for the sum of two products.
    localparam int prod_w = din_w + 1 + twidd_w + 1;
    localparam int prod_point = din_point + twidd_point;

    typedef logic signed [din_w-1:0] sample_t;

    // one bit of growth from the subtraction.
    typedef logic signed [din_w:0] comb_t;

    typedef logic signed [twidd_w-1:0] twidd_t;

    // real part in the upper half.
    typedef logic [2*twidd_w-1:0] twidd_word_t;

    typedef logic signed [dout_w-1:0] dout_t;

    typedef logic signed [prod_w-1:0] prod_t;

endpackage

`default_nettype wire

//--- design/msdft_top.sv
`default_nettype none

module msdft_top #(
    parameter int DFT_LEN = 64
) (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire msdft_pkg::sample_t          din_re,
    input  wire msdft_pkg::sample_t          din_im,
    input  wire logic                        din_valid,
    input  wire logic [$clog2(DFT_LEN)-1:0]  len_m1,
    input  wire logic [$clog2(DFT_LEN)-1:0]  cfg_addr,
    input  wire msdft_pkg::twidd_word_t      cfg_data,
    input  wire logic                        cfg_we,
    output msdft_pkg::twidd_word_t           cfg_dout,
    output msdft_pkg::dout_t                 dout_re,
    output msdft_pkg::dout_t                 dout_im,
    output logic                             dout_valid
);

    logic [$clog2(DFT_LEN)-1:0] len_r;
    logic [$clog2(DFT_LEN)-1:0] twidd_addr;
    msdft_pkg::twidd_word_t     twidd_word;

    // window length, change it only together with rst.
    always_ff @(posedge clk) begin
        len_r <= len_m1;
    end

    msdft #(.DFT_LEN(DFT_LEN)) core_inst (
        .clk        (clk),
        .rst        (rst),
        .din_re     (din_re),
        .din_im     (din_im),
        .din_valid  (din_valid),
        .len_m1     (len_r),
        .twidd_addr (twidd_addr),
        .twidd_word (twidd_word),
        .dout_re    (dout_re),
        .dout_im    (dout_im),
        .dout_valid (dout_valid)
    );

    twiddle_ram #(.DFT_LEN(DFT_LEN)) ram_inst (
        .clk      (clk),
        .rd_addr  (twidd_addr),
        .rd_data  (twidd_word),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .cfg_we   (cfg_we),
        .cfg_dout (cfg_dout)
    );

endmodule

`default_nettype wire

//--- design/signed_cast.sv
`default_nettype none

module signed_cast #(
    parameter int DIN_W = 40,
    parameter int DIN_POINT = 29
) (
    input  wire logic                     clk,
    input  wire logic signed [DIN_W-1:0]  din,
    input  wire logic                     din_valid,
    output msdft_pkg::dout_t              dout,
    output logic                          dout_valid
);

    // surplus fraction bits, expects DIN_POINT >= dout_point.
    localparam int shift = DIN_POINT - msdft_pkg::dout_point;

    // wide enough to hold the input and both output limits.
    localparam int ext_w = DIN_W + msdft_pkg::dout_w;

    localparam logic signed [ext_w-1:0] out_max =
        (ext_w'(1) <<< (msdft_pkg::dout_w - 1)) - ext_w'(1);
    localparam logic signed [ext_w-1:0] out_min = -out_max - ext_w'(1);

    logic signed [ext_w-1:0] din_ext;
    logic signed [ext_w-1:0] shifted;

    assign din_ext = din;              // sign extends.
    assign shifted = din_ext >>> shift; // floor.

    always_ff @(posedge clk) begin
        if (shifted > out_max) begin
            dout <= out_max[msdft_pkg::dout_w-1:0];
        end else if (shifted < out_min) begin
            dout <= out_min[msdft_pkg::dout_w-1:0];
        end else begin
            dout <= shifted[msdft_pkg::dout_w-1:0];
        end
        dout_valid <= din_valid;
    end

endmodule

`default_nettype wire

//--- design/twiddle_ram.sv
`default_nettype none

module twiddle_ram #(
    parameter int DFT_LEN = 64
) (
    input  wire logic                        clk,

    input  wire logic [$clog2(DFT_LEN)-1:0]  rd_addr,
    output msdft_pkg::twidd_word_t           rd_data,

    input  wire logic [$clog2(DFT_LEN)-1:0]  cfg_addr,
    input  wire msdft_pkg::twidd_word_t      cfg_data,
    input  wire logic                        cfg_we,
    output msdft_pkg::twidd_word_t           cfg_dout
);

    msdft_pkg::twidd_word_t mem [DFT_LEN];

    // table starts out all zero.
    initial begin
        for (int i = 0; i < DFT_LEN; i++) begin
            mem[i] = '0;
        end
    end

    // datapath port, read only.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // config port, write-first.
    always_ff @(posedge clk) begin
        if (cfg_we) begin
            mem[cfg_addr] <= cfg_data;
            cfg_dout <= cfg_data;
        end else begin
            cfg_dout <= mem[cfg_addr];
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
design/msdft_pkg.sv
design/comb.sv
design/twiddle_ram.sv
design/complex_mult.sv
design/signed_cast.sv
design/msdft.sv
design/msdft_top.sv
bench/msdft_checker.sv
bench/msdft_tb.sv
